// ==== build.f ====
+incdir+verilog
verilog/l1_store_pkg.sv
verilog/store_arbiter.sv
verilog/store_line_data.sv
verilog/store_buffer_ctrl.sv
verilog/l2_store_port.sv
verilog/l1_store_top.sv
dv/l1_store_top_tb.sv

// ==== dv/l1_store_top_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module l1_store_top_tb;

	import l1_store_pkg::*;

	localparam int max_rows = 64;
	localparam int op_idle = 0;
	localparam int op_store = 1;
	localparam int op_request = 2;
	localparam int op_ack = 3;
	localparam int op_respond = 4;
	localparam int op_bypass = 5;

	logic clk;
	logic reset;
	logic store_en;
	addr_t store_addr;
	line_mask_t store_mask;
	line_data_t store_data;
	logic store_sync;
	thread_idx_t store_thread;
	logic store_rollback;
	logic store_sync_success;
	addr_t bypass_addr;
	thread_idx_t bypass_thread;
	line_mask_t bypass_mask;
	line_data_t bypass_data;
	logic [threads_per_core-1:0] wake_bitmap;
	logic l2_req;
	logic l2_ack;
	addr_t l2_addr;
	line_mask_t l2_mask;
	line_data_t l2_data;
	logic l2_sync;
	thread_idx_t l2_idx;
	logic l2_resp_req;
	thread_idx_t l2_resp_idx;
	logic l2_resp_sync_success;
	logic l2_resp_ack;

	// Stimulus table with one entry per row in each array
	string row_name[max_rows];
	int row_op[max_rows];
	thread_idx_t row_thread[max_rows];
	addr_t row_addr[max_rows];
	line_mask_t row_mask[max_rows];
	logic row_sync[max_rows];
	logic row_hold[max_rows];
	int row_delay[max_rows];
	logic row_success[max_rows];
	logic [3:0] row_expected[max_rows];
	int row_count;

	// Expected contents of every pending entry
	logic model_valid[threads_per_core];
	logic model_sync[threads_per_core];
	addr_t model_addr[threads_per_core];
	line_mask_t model_mask[threads_per_core];
	line_data_t model_data[threads_per_core];

	integer seed;
	int cycle_count;
	int timeout_limit = 1000;
	int current_row;
	int row_errors;
	int failed_rows;

	l1_store_top u_dut(.*);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count > timeout_limit)
		begin
			$display("Timeout after %0d cycles in row %0d, the DUT stopped answering",
				cycle_count, current_row);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	function automatic line_data_t lane_bits(input line_mask_t mask);
		line_data_t bits;

		for (int lane = 0; lane < line_bytes; lane++)
			bits[lane * 8+:8] = {8{mask[lane]}};
		return bits;
	endfunction

	function automatic line_data_t merge_lanes(input line_data_t old_data,
		input line_data_t new_data, input line_mask_t mask);
		return (old_data & ~lane_bits(mask)) | (new_data & lane_bits(mask));
	endfunction

	task automatic add_row(input string name, input int op, input int thread, input addr_t addr,
		input line_mask_t mask, input logic sync, input logic hold, input int delay,
		input logic success, input logic [3:0] expected);
		row_name[row_count] = name;
		row_op[row_count] = op;
		row_thread[row_count] = thread_idx_t'(thread);
		row_addr[row_count] = addr;
		row_mask[row_count] = mask;
		row_sync[row_count] = sync;
		row_hold[row_count] = hold;
		row_delay[row_count] = delay;
		row_success[row_count] = success;
		row_expected[row_count] = expected;
		row_count = row_count + 1;
	endtask

	task automatic report_mismatch(input string what, input line_data_t expected,
		input line_data_t actual);
		$display("Error in %s: %s expected %0h, actual %0h", row_name[current_row], what,
			expected, actual);
		row_errors = row_errors + 1;
	endtask

	task automatic check_idle_outputs();
		if (l2_req !== 1'b0)
			report_mismatch("l2_req", 0, l2_req);
		if (store_rollback !== 1'b0)
			report_mismatch("store_rollback", 0, store_rollback);
		if (bypass_mask !== '0)
			report_mismatch("bypass_mask", 0, bypass_mask);
	endtask

	task automatic apply_store(input int r);
		thread_idx_t t;
		line_data_t data;
		logic enters;

		t = row_thread[r];
		data = {$random(seed), $random(seed), $random(seed), $random(seed)};
		store_en = 1'b1;
		store_addr = row_addr[r];
		store_mask = row_mask[r];
		store_data = data;
		store_sync = row_sync[r];
		store_thread = t;
		@(posedge clk);
		#1;
		store_en = 1'b0;
		store_sync = 1'b0;
		if (store_rollback !== row_expected[r][0])
			report_mismatch("store_rollback", row_expected[r][0], store_rollback);
		if (store_sync_success !== row_expected[r][1])
			report_mismatch("store_sync_success", row_expected[r][1], store_sync_success);

		// A first synchronized store still claims a free entry while it rolls back
		enters = !model_valid[t] && (!row_expected[r][0] || row_sync[r]);
		if (enters)
		begin
			model_valid[t] = 1'b1;
			model_sync[t] = row_sync[r];
			model_addr[t] = row_addr[r] & ~addr_t'(line_bytes - 1);
			model_mask[t] = row_mask[r];
			model_data[t] = merge_lanes('0, data, row_mask[r]);
		end
		else if (!row_expected[r][0] && model_sync[t])
			model_valid[t] = 1'b0;
		else if (!row_expected[r][0])
		begin
			model_mask[t] = model_mask[t] | row_mask[r];
			model_data[t] = merge_lanes(model_data[t], data, row_mask[r]);
		end
	endtask

	task automatic release_request();
		l2_ack = 1'b1;
		while (l2_req !== 1'b0)
		begin
			@(posedge clk);
			#1;
		end
		l2_ack = 1'b0;
		@(posedge clk);
		#1;
	endtask

	task automatic capture_request(input int r);
		thread_idx_t t;
		line_data_t lanes;

		t = row_thread[r];
		while (l2_req !== 1'b1)
		begin
			@(posedge clk);
			#1;
		end
		lanes = lane_bits(model_mask[t]);
		if (l2_idx !== t)
			report_mismatch("l2_idx", t, l2_idx);
		if (l2_sync !== row_expected[r][0])
			report_mismatch("l2_sync", row_expected[r][0], l2_sync);
		if (l2_addr !== model_addr[t])
			report_mismatch("l2_addr", model_addr[t], l2_addr);
		if (l2_mask !== model_mask[t])
			report_mismatch("l2_mask", model_mask[t], l2_mask);
		if ((l2_data & lanes) !== (model_data[t] & lanes))
			report_mismatch("l2_data", model_data[t] & lanes, l2_data & lanes);
		if (!row_hold[r])
		begin
			repeat (row_delay[r])
			begin
				@(posedge clk);
				#1;
			end
			release_request();
		end
	endtask

	task automatic ack_held_request();
		if (l2_req !== 1'b1)
		begin
			$display("Error in %s: no request is waiting for an ack", row_name[current_row]);
			row_errors = row_errors + 1;
		end
		release_request();
	endtask

	task automatic deliver_response(input int r);
		thread_idx_t t;

		t = row_thread[r];
		l2_resp_req = 1'b1;
		l2_resp_idx = t;
		l2_resp_sync_success = row_success[r];
		while (l2_resp_ack !== 1'b1)
		begin
			@(posedge clk);
			#1;
		end

		// The response is being delivered in this cycle
		if (wake_bitmap !== row_expected[r])
			report_mismatch("wake_bitmap", row_expected[r], wake_bitmap);
		l2_resp_req = 1'b0;
		while (l2_resp_ack !== 1'b0)
		begin
			@(posedge clk);
			#1;
		end
		if (!model_sync[t])
			model_valid[t] = 1'b0;
	endtask

	task automatic lookup_bypass(input int r);
		thread_idx_t t;
		line_mask_t expected_mask;
		line_data_t lanes;

		t = row_thread[r];
		bypass_addr = row_addr[r];
		bypass_thread = t;
		@(posedge clk);
		#1;
		expected_mask = row_expected[r][0] ? model_mask[t] : '0;
		lanes = lane_bits(expected_mask);
		if (bypass_mask !== expected_mask)
			report_mismatch("bypass_mask", expected_mask, bypass_mask);
		if ((bypass_data & lanes) !== (model_data[t] & lanes))
			report_mismatch("bypass_data", model_data[t] & lanes, bypass_data & lanes);
	endtask

	task automatic build_table();
		add_row("reset_outputs", op_idle, 0, 32'h0, 16'h0, 0, 0, 0, 0, 4'h0);
		add_row("plain_store", op_store, 0, 32'h1000_0024, 16'h00f0, 0, 0, 0, 0, 4'h0);
		add_row("plain_request", op_request, 0, 32'h0, 16'h0, 0, 0, 2, 0, 4'h0);
		add_row("plain_response", op_respond, 0, 32'h0, 16'h0, 0, 0, 0, 0, 4'h0);
		add_row("bypass_freed_entry", op_bypass, 0, 32'h1000_0020, 16'h0, 0, 0, 0, 0, 4'h0);
		add_row("single_request_only", op_idle, 0, 32'h0, 16'h0, 0, 0, 0, 0, 4'h0);
		add_row("block_store_t0", op_store, 0, 32'h2000_0000, 16'hffff, 0, 0, 0, 0, 4'h0);
		add_row("block_request_t0", op_request, 0, 32'h0, 16'h0, 0, 1, 0, 0, 4'h0);
		add_row("combine_first_t1", op_store, 1, 32'h3000_0010, 16'h00ff, 0, 0, 0, 0, 4'h0);
		add_row("combine_second_t1", op_store, 1, 32'h3000_0018, 16'h0f0f, 0, 0, 0, 0, 4'h0);
		add_row("bypass_hit_t1", op_bypass, 1, 32'h3000_001c, 16'h0, 0, 0, 0, 0, 4'h1);
		add_row("bypass_other_line", op_bypass, 1, 32'h3000_0020, 16'h0, 0, 0, 0, 0, 4'h0);
		add_row("bypass_other_thread", op_bypass, 0, 32'h3000_0010, 16'h0, 0, 0, 0, 0, 4'h0);
		add_row("rollback_other_line", op_store, 1, 32'h4000_0000, 16'h0001, 0, 0, 0, 0, 4'h1);
		add_row("release_t0", op_ack, 0, 32'h0, 16'h0, 0, 0, 0, 0, 4'h0);
		add_row("combined_request_t1", op_request, 1, 32'h0, 16'h0, 0, 0, 1, 0, 4'h0);
		add_row("wake_on_response_t1", op_respond, 1, 32'h0, 16'h0, 0, 0, 0, 0, 4'h2);
		add_row("response_t0", op_respond, 0, 32'h0, 16'h0, 0, 0, 0, 0, 4'h0);
		add_row("sync_first_t2", op_store, 2, 32'h5000_0040, 16'hffff, 1, 0, 0, 0, 4'h1);
		add_row("sync_request_t2", op_request, 2, 32'h0, 16'h0, 0, 0, 3, 0, 4'h1);
		add_row("sync_response_t2", op_respond, 2, 32'h0, 16'h0, 0, 0, 0, 1, 4'h4);
		add_row("sync_restart_t2", op_store, 2, 32'h5000_0040, 16'hffff, 1, 0, 0, 0, 4'h2);
		add_row("after_sync_store_t2", op_store, 2, 32'h5000_0080, 16'h000f, 0, 0, 0, 0, 4'h0);
		add_row("after_sync_request_t2", op_request, 2, 32'h0, 16'h0, 0, 0, 0, 0, 4'h0);
		add_row("after_sync_response_t2", op_respond, 2, 32'h0, 16'h0, 0, 0, 0, 0, 4'h0);
		add_row("sync_first_t3", op_store, 3, 32'h6000_0000, 16'h00ff, 1, 0, 0, 0, 4'h1);
		add_row("sync_request_t3", op_request, 3, 32'h0, 16'h0, 0, 0, 1, 0, 4'h1);
		add_row("sync_fail_response_t3", op_respond, 3, 32'h0, 16'h0, 0, 0, 0, 0, 4'h8);
		add_row("sync_fail_restart_t3", op_store, 3, 32'h6000_0000, 16'h00ff, 1, 0, 0, 0, 4'h0);
		add_row("bypass_freed_sync_t3", op_bypass, 3, 32'h6000_0000, 16'h0, 0, 0, 0, 0, 4'h0);
		add_row("fair_store_t2", op_store, 2, 32'h7000_0000, 16'hf000, 0, 0, 0, 0, 4'h0);
		add_row("fair_block_t2", op_request, 2, 32'h0, 16'h0, 0, 1, 0, 0, 4'h0);
		add_row("fair_store_t1", op_store, 1, 32'h7100_0004, 16'h00f0, 0, 0, 0, 0, 4'h0);
		add_row("fair_store_t0", op_store, 0, 32'h7200_0008, 16'h0f00, 0, 0, 0, 0, 4'h0);
		add_row("fair_store_t3", op_store, 3, 32'h7300_000c, 16'hf000, 0, 0, 0, 0, 4'h0);
		add_row("fair_release_t2", op_ack, 2, 32'h0, 16'h0, 0, 0, 0, 0, 4'h0);
		add_row("fair_first_t3", op_request, 3, 32'h0, 16'h0, 0, 0, 1, 0, 4'h0);
		add_row("fair_second_t0", op_request, 0, 32'h0, 16'h0, 0, 0, 1, 0, 4'h0);
		add_row("fair_third_t1", op_request, 1, 32'h0, 16'h0, 0, 0, 1, 0, 4'h0);
		add_row("fair_response_t2", op_respond, 2, 32'h0, 16'h0, 0, 0, 0, 0, 4'h0);
		add_row("fair_response_t3", op_respond, 3, 32'h0, 16'h0, 0, 0, 0, 0, 4'h0);
		add_row("fair_response_t0", op_respond, 0, 32'h0, 16'h0, 0, 0, 0, 0, 4'h0);
		add_row("fair_response_t1", op_respond, 1, 32'h0, 16'h0, 0, 0, 0, 0, 4'h0);
	endtask

	initial
	begin
		seed = 32'h8015;
		reset = 1'b1;
		store_en = 1'b0;
		store_addr = '0;
		store_mask = '0;
		store_data = '0;
		store_sync = 1'b0;
		store_thread = '0;
		bypass_addr = '0;
		bypass_thread = '0;
		l2_ack = 1'b0;
		l2_resp_req = 1'b0;
		l2_resp_idx = '0;
		l2_resp_sync_success = 1'b0;
		cycle_count = 0;
		current_row = 0;
		failed_rows = 0;
		row_count = 0;
		for (int i = 0; i < threads_per_core; i++)
		begin
			model_valid[i] = 1'b0;
			model_sync[i] = 1'b0;
			model_addr[i] = '0;
			model_mask[i] = '0;
			model_data[i] = '0;
		end
		build_table();
		timeout_limit = 200 * row_count + 100;

		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		for (int r = 0; r < row_count; r++)
		begin
			current_row = r;
			row_errors = 0;
			case (row_op[r])
				op_idle: check_idle_outputs();
				op_store: apply_store(r);
				op_request: capture_request(r);
				op_ack: ack_held_request();
				op_respond: deliver_response(r);
				default: lookup_bypass(r);
			endcase
			if (row_errors == 0)
				$display("Test %0d %s: ok", r, row_name[r]);
			else
			begin
				failed_rows = failed_rows + 1;
				$display("Test %0d %s: failed with %0d errors", r, row_name[r], row_errors);
			end
		end

		$display("Tests run: %0d, passed: %0d, failed: %0d", row_count,
			row_count - failed_rows, failed_rows);
		if (failed_rows == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/l1_store_pkg.sv ====
`default_nettype none

// Shared geometry for the L1 store buffer and its L2 link

package l1_store_pkg;

	// One pending store entry per hardware thread
	localparam int threads_per_core = 4;
	localparam int thread_idx_width = 2;

	// Cache line geometry
	localparam int line_bytes = 16;
	localparam int line_bits = 128;

	// Byte address layout. The low offset_width bits select a byte within a line
	localparam int addr_width = 32;
	localparam int offset_width = 4;

	typedef logic [thread_idx_width-1:0] thread_idx_t;

	typedef logic [line_bytes-1:0] line_mask_t;

	typedef logic [line_bits-1:0] line_data_t;

	typedef logic [addr_width-1:0] addr_t;

endpackage

`default_nettype wire

// ==== verilog/l1_store_top.sv ====
`timescale 1ns/100ps
`default_nettype none

// Store side of the L1 data cache, from the pipeline to the L2 link

module l1_store_top(
	input logic clk,
	input logic reset,

	// Store from the pipeline
	input logic store_en,
	input l1_store_pkg::addr_t store_addr,
	input l1_store_pkg::line_mask_t store_mask,
	input l1_store_pkg::line_data_t store_data,
	input logic store_sync,
	input l1_store_pkg::thread_idx_t store_thread,
	output logic store_rollback,
	output logic store_sync_success,

	// Load bypass
	input l1_store_pkg::addr_t bypass_addr,
	input l1_store_pkg::thread_idx_t bypass_thread,
	output l1_store_pkg::line_mask_t bypass_mask,
	output l1_store_pkg::line_data_t bypass_data,
	output logic [l1_store_pkg::threads_per_core-1:0] wake_bitmap,

	// L2 link
	output logic l2_req,
	input logic l2_ack,
	output l1_store_pkg::addr_t l2_addr,
	output l1_store_pkg::line_mask_t l2_mask,
	output l1_store_pkg::line_data_t l2_data,
	output logic l2_sync,
	output l1_store_pkg::thread_idx_t l2_idx,
	input logic l2_resp_req,
	input l1_store_pkg::thread_idx_t l2_resp_idx,
	input logic l2_resp_sync_success,
	output logic l2_resp_ack);

	import l1_store_pkg::*;

	logic [threads_per_core-1:0] addr_match;
	logic [threads_per_core-1:0] send_request;
	logic [threads_per_core-1:0] grant_oh;
	logic [threads_per_core-1:0] entry_valid;
	logic [threads_per_core-1:0] entry_sync;
	thread_idx_t grant_idx;
	logic grant_valid;
	logic port_ready;
	logic send_taken;
	logic write_en;
	logic write_combine;
	addr_t read_addr;
	line_mask_t read_mask;
	line_data_t read_data;
	logic response_valid;
	thread_idx_t response_idx;
	logic response_sync_success;

	assign grant_valid = |grant_oh;
	assign send_taken = grant_valid && port_ready;

	store_buffer_ctrl u_ctrl(
		.clk(clk),
		.reset(reset),
		.store_en(store_en),
		.store_sync(store_sync),
		.store_thread(store_thread),
		.addr_match(addr_match),
		.send_request(send_request),
		.send_taken(send_taken),
		.grant_oh(grant_oh),
		.response_valid(response_valid),
		.response_sync_success(response_sync_success),
		.response_idx(response_idx),
		.write_en(write_en),
		.write_combine(write_combine),
		.entry_valid(entry_valid),
		.entry_sync(entry_sync),
		.store_rollback(store_rollback),
		.store_sync_success(store_sync_success),
		.wake_bitmap(wake_bitmap));

	store_line_data u_line_data(
		.clk(clk),
		.reset(reset),
		.write_en(write_en),
		.write_thread(store_thread),
		.write_combine(write_combine),
		.write_mask(store_mask),
		.write_data(store_data),
		.write_addr(store_addr),
		.addr_match(addr_match),
		.read_thread(grant_idx),
		.read_addr(read_addr),
		.read_mask(read_mask),
		.read_data(read_data),
		.bypass_addr(bypass_addr),
		.bypass_thread(bypass_thread),
		.bypass_valid_entry(entry_valid[bypass_thread]),
		.bypass_mask(bypass_mask),
		.bypass_data(bypass_data));

	store_arbiter u_arbiter(
		.clk(clk),
		.reset(reset),
		.request(send_request),
		.advance(send_taken),
		.grant_oh(grant_oh),
		.grant_idx(grant_idx));

	l2_store_port u_l2_port(
		.clk(clk),
		.reset(reset),
		.grant_valid(grant_valid),
		.grant_idx(grant_idx),
		.send_addr(read_addr),
		.send_mask(read_mask),
		.send_data(read_data),
		.send_sync(entry_sync[grant_idx]),
		.port_ready(port_ready),
		.l2_req(l2_req),
		.l2_ack(l2_ack),
		.l2_addr(l2_addr),
		.l2_mask(l2_mask),
		.l2_data(l2_data),
		.l2_sync(l2_sync),
		.l2_idx(l2_idx),
		.l2_resp_req(l2_resp_req),
		.l2_resp_idx(l2_resp_idx),
		.l2_resp_sync_success(l2_resp_sync_success),
		.l2_resp_ack(l2_resp_ack),
		.response_valid(response_valid),
		.response_idx(response_idx),
		.response_sync_success(response_sync_success));

endmodule

`default_nettype wire

// ==== verilog/l2_store_port.sv ====
`timescale 1ns/100ps
`default_nettype none

// Four-phase request side and four-phase response side of the L2 store link

module l2_store_port(
	input logic clk,
	input logic reset,

	// Winning entry and its payload
	input logic grant_valid,
	input l1_store_pkg::thread_idx_t grant_idx,
	input l1_store_pkg::addr_t send_addr,
	input l1_store_pkg::line_mask_t send_mask,
	input l1_store_pkg::line_data_t send_data,
	input logic send_sync,
	output logic port_ready,

	// Request toward L2
	output logic l2_req,
	input logic l2_ack,
	output l1_store_pkg::addr_t l2_addr,
	output l1_store_pkg::line_mask_t l2_mask,
	output l1_store_pkg::line_data_t l2_data,
	output logic l2_sync,
	output l1_store_pkg::thread_idx_t l2_idx,

	// Response from L2
	input logic l2_resp_req,
	input l1_store_pkg::thread_idx_t l2_resp_idx,
	input logic l2_resp_sync_success,
	output logic l2_resp_ack,

	// Delivered response
	output logic response_valid,
	output l1_store_pkg::thread_idx_t response_idx,
	output logic response_sync_success);

	import l1_store_pkg::*;

	typedef enum logic [1:0] {
		req_idle,
		req_wait_ack,
		req_wait_release
	} req_state_t;

	req_state_t req_state;

	assign port_ready = req_state == req_idle;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			req_state <= req_idle;
			l2_req <= 1'b0;
		end
		else
		begin
			case (req_state)
				req_idle:
					if (grant_valid)
					begin
						l2_req <= 1'b1;
						req_state <= req_wait_ack;
					end
				req_wait_ack:
					if (l2_ack)
					begin
						l2_req <= 1'b0;
						req_state <= req_wait_release;
					end
				default:
					if (!l2_ack)
						req_state <= req_idle;
			endcase
		end
	end

	// Payload stays put while l2_req is high since it only loads when idle
	always_ff @(posedge clk)
	begin
		if (port_ready && grant_valid)
		begin
			l2_addr <= send_addr;
			l2_mask <= send_mask;
			l2_data <= send_data;
			l2_sync <= send_sync;
			l2_idx <= grant_idx;
		end
	end

	// l2_resp_ack doubles as the state of the response side
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			l2_resp_ack <= 1'b0;
			response_valid <= 1'b0;
		end
		else
		begin
			response_valid <= l2_resp_req && !l2_resp_ack;
			if (!l2_resp_ack && l2_resp_req)
				l2_resp_ack <= 1'b1;
			else if (l2_resp_ack && !l2_resp_req)
				l2_resp_ack <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (l2_resp_req && !l2_resp_ack)
		begin
			response_idx <= l2_resp_idx;
			response_sync_success <= l2_resp_sync_success;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/store_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

// Round-robin pick among the entries that have a line ready to send

module store_arbiter(
	input logic clk,
	input logic reset,
	input logic [l1_store_pkg::threads_per_core-1:0] request,
	input logic advance,
	output logic [l1_store_pkg::threads_per_core-1:0] grant_oh,
	output l1_store_pkg::thread_idx_t grant_idx);

	import l1_store_pkg::*;

	thread_idx_t last_winner;

	// Search starts at the entry just after the last winner and wraps around
	always_comb
	begin
		thread_idx_t candidate;
		logic found;

		grant_oh = '0;
		found = 1'b0;
		for (int offset = 1; offset <= threads_per_core; offset++)
		begin
			candidate = thread_idx_t'(last_winner + offset);
			if (!found && request[candidate])
			begin
				grant_oh[candidate] = 1'b1;
				found = 1'b1;
			end
		end
	end

	always_comb
	begin
		grant_idx = '0;
		for (int i = 0; i < threads_per_core; i++)
		begin
			if (grant_oh[i])
				grant_idx = grant_idx | thread_idx_t'(i);
		end
	end

	// Starting at the last index puts thread 0 first after reset
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			last_winner <= thread_idx_t'(threads_per_core - 1);
		else if (advance)
			last_winner <= grant_idx;
	end

endmodule

`default_nettype wire

// ==== verilog/store_buffer_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

// Per-thread entry state and the accept, merge and rollback decisions for stores

module store_buffer_ctrl(
	input logic clk,
	input logic reset,

	// Store from the pipeline
	input logic store_en,
	input logic store_sync,
	input l1_store_pkg::thread_idx_t store_thread,
	input logic [l1_store_pkg::threads_per_core-1:0] addr_match,

	// Send arbitration
	output logic [l1_store_pkg::threads_per_core-1:0] send_request,
	input logic send_taken,
	input logic [l1_store_pkg::threads_per_core-1:0] grant_oh,

	// Responses from L2
	input logic response_valid,
	input logic response_sync_success,
	input l1_store_pkg::thread_idx_t response_idx,

	// Data store control
	output logic write_en,
	output logic write_combine,
	output logic [l1_store_pkg::threads_per_core-1:0] entry_valid,
	output logic [l1_store_pkg::threads_per_core-1:0] entry_sync,

	// Back to the pipeline
	output logic store_rollback,
	output logic store_sync_success,
	output logic [l1_store_pkg::threads_per_core-1:0] wake_bitmap);

	import l1_store_pkg::*;

	logic [threads_per_core-1:0] valid;
	logic [threads_per_core-1:0] sent;
	logic [threads_per_core-1:0] resp_received;
	logic [threads_per_core-1:0] sync;
	logic [threads_per_core-1:0] sync_success;
	logic [threads_per_core-1:0] waiting;

	logic [threads_per_core-1:0] store_here;
	logic [threads_per_core-1:0] send_this;
	logic [threads_per_core-1:0] can_combine;
	logic [threads_per_core-1:0] restart;
	logic [threads_per_core-1:0] update;
	logic [threads_per_core-1:0] rollback;

	always_comb
	begin
		for (int i = 0; i < threads_per_core; i++)
		begin
			store_here[i] = store_en && store_thread == thread_idx_t'(i);
			send_this[i] = send_taken && grant_oh[i];

			// Once the line is on its way to L2 its bytes can no longer change
			can_combine[i] = valid[i] && addr_match[i] && !sync[i] && !store_sync
				&& !sent[i] && !send_this[i];

			// The thread comes back after the response to pick up the success flag
			restart[i] = store_sync && valid[i] && sync[i] && resp_received[i];
			update[i] = store_here[i] && !restart[i] && (!valid[i] || can_combine[i]);

			// A first synchronized store suspends its thread even when the entry is free
			if (store_sync)
				rollback[i] = store_here[i] && !restart[i];
			else
				rollback[i] = store_here[i] && valid[i] && !can_combine[i];
		end
	end

	assign write_en = |update;
	assign write_combine = |(update & can_combine);
	assign send_request = valid & ~sent;
	assign entry_valid = valid;
	assign entry_sync = sync;
	assign wake_bitmap = {threads_per_core{response_valid}} & waiting;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			valid <= '0;
			sent <= '0;
			resp_received <= '0;
			sync <= '0;
			sync_success <= '0;
			waiting <= '0;
			store_rollback <= 1'b0;
			store_sync_success <= 1'b0;
		end
		else
		begin
			for (int i = 0; i < threads_per_core; i++)
			begin
				if (send_this[i])
					sent[i] <= 1'b1;

				// Any delivered response wakes every waiting thread
				if (response_valid)
					waiting[i] <= 1'b0;

				if (response_valid && response_idx == thread_idx_t'(i))
				begin
					if (sync[i])
					begin
						resp_received[i] <= 1'b1;
						sync_success[i] <= response_sync_success;
					end
					else
						valid[i] <= 1'b0;
				end

				if (store_here[i] && restart[i])
					valid[i] <= 1'b0;

				if (update[i] && !can_combine[i])
				begin
					valid[i] <= 1'b1;
					sync[i] <= store_sync;
					sent[i] <= 1'b0;
					resp_received[i] <= 1'b0;
				end

				if (rollback[i])
					waiting[i] <= 1'b1;
			end

			store_rollback <= |rollback;
			store_sync_success <= |(store_here & restart & sync_success);
		end
	end

endmodule

`default_nettype wire

// ==== verilog/store_line_data.sv ====
`timescale 1ns/100ps
`default_nettype none

// Line data, byte mask and aligned address of every pending store entry

module store_line_data(
	input logic clk,
	input logic reset,

	// Store from the pipeline
	input logic write_en,
	input l1_store_pkg::thread_idx_t write_thread,
	input logic write_combine,
	input l1_store_pkg::line_mask_t write_mask,
	input l1_store_pkg::line_data_t write_data,
	input l1_store_pkg::addr_t write_addr,
	output logic [l1_store_pkg::threads_per_core-1:0] addr_match,

	// Entry selected for sending to L2
	input l1_store_pkg::thread_idx_t read_thread,
	output l1_store_pkg::addr_t read_addr,
	output l1_store_pkg::line_mask_t read_mask,
	output l1_store_pkg::line_data_t read_data,

	// Load bypass lookup
	input l1_store_pkg::addr_t bypass_addr,
	input l1_store_pkg::thread_idx_t bypass_thread,
	input logic bypass_valid_entry,
	output l1_store_pkg::line_mask_t bypass_mask,
	output l1_store_pkg::line_data_t bypass_data);

	import l1_store_pkg::*;

	line_data_t line_data[threads_per_core];
	line_mask_t line_mask[threads_per_core];
	addr_t line_addr[threads_per_core];
	addr_t aligned_write_addr;
	addr_t aligned_bypass_addr;

	assign aligned_write_addr = {write_addr[addr_width-1:offset_width], {offset_width{1'b0}}};
	assign aligned_bypass_addr = {bypass_addr[addr_width-1:offset_width],
		{offset_width{1'b0}}};

	// The controller qualifies these with the valid flag of each entry
	always_comb
	begin
		for (int i = 0; i < threads_per_core; i++)
			addr_match[i] = line_addr[i] == aligned_write_addr;
	end

	// Only the enabled byte lanes are written so a combine keeps older bytes
	always_ff @(posedge clk)
	begin
		if (write_en)
		begin
			for (int lane = 0; lane < line_bytes; lane++)
			begin
				if (write_mask[lane])
					line_data[write_thread][lane * 8+:8] <= write_data[lane * 8+:8];
			end

			if (write_combine)
			begin
				line_mask[write_thread] <= line_mask[write_thread] | write_mask;
			end
			else
			begin
				line_mask[write_thread] <= write_mask;
				line_addr[write_thread] <= aligned_write_addr;
			end
		end
	end

	assign read_addr = line_addr[read_thread];
	assign read_mask = line_mask[read_thread];
	assign read_data = line_data[read_thread];

	// A zero mask tells the load path that nothing is forwarded
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			bypass_mask <= '0;
		else if (bypass_valid_entry && line_addr[bypass_thread] == aligned_bypass_addr)
			bypass_mask <= line_mask[bypass_thread];
		else
			bypass_mask <= '0;
	end

	always_ff @(posedge clk)
	begin
		bypass_data <= line_data[bypass_thread];
	end

endmodule

`default_nettype wire
